//--- bench/issueBench.sv
`timescale 1ns/1ns
`default_nettype none

module issueBench;

	import issuePkg::*;

	localparam int acceptTimeout = 64;
	localparam int drainTimeout = 200;

	// Expected contents of the issue register
	typedef struct packed {
		logic [regAddrWidth-1:0] rd;
		logic we;
		aluOpT aluOp;
		logic [xlen-1:0] opA;
		logic [xlen-1:0] opB;
	} instT;

	// Write-back waiting in the emulated commit stage
	typedef struct packed {
		logic [31:0] due;
		logic [regAddrWidth-1:0] addr;
		logic [xlen-1:0] data;
	} wbT;

	logic clk = 1'b0;
	logic nrst;
	logic inValid;
	logic inReady;
	logic [regAddrWidth-1:0] inRs1;
	logic [regAddrWidth-1:0] inRs2;
	logic [regAddrWidth-1:0] inRd;
	logic inWe;
	aluOpT inAluOp;
	operandSelT inBSel;
	logic [xlen-1:0] inImm;
	logic wbValid;
	logic [regAddrWidth-1:0] wbAddr;
	logic [xlen-1:0] wbData;
	logic flush;
	logic outValid;
	logic outReady;
	logic [regAddrWidth-1:0] outRd;
	logic outWe;
	aluOpT outAluOp;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;

	integer seed;
	int cycle;
	int checkCount;
	int errorCount;
	int acceptCount;
	int dispatchCount;
	int flushCount;
	int testErrors;
	int testChecks;
	logic lastAccept;
	logic fullRate;
	logic [xlen-1:0] modelRegs [regCount];
	logic [regCount-1:0] modelBusy;
	instT held[$];
	wbT wbQueue[$];

	always #4 clk = ~clk;

	issueUnit uut (.*);

	task automatic compareData(input string name, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		end
	endtask

	task automatic compareAluOp(input string name, input aluOpT expected, input aluOpT actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
		end
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
		end
	endtask

	// Register busy in flight or the destination of the held instruction
	function automatic logic regBlocked(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
		begin
			return 1'b0;
		end
		if (held.size() != 0 && held[0].we && held[0].rd == addr)
		begin
			return 1'b1;
		end
		return modelBusy[addr] && !(wbValid && wbAddr == addr);
	endfunction

	// Architectural value seen by a read in this cycle
	function automatic logic [xlen-1:0] readModel(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
		begin
			return '0;
		end
		if (wbValid && wbAddr == addr)
		begin
			return wbData;
		end
		return modelRegs[addr];
	endfunction

	// Runs at the falling edge and predicts the coming rising edge
	task automatic checkCycle();
		logic expReady;
		logic dispatchNow;
		instT next;
		wbT result;
		expReady = !flush && (held.size() == 0 || outReady);
		if (inValid && (regBlocked(inRs1) || regBlocked(inRs2) || (inWe && regBlocked(inRd))))
		begin
			expReady = 1'b0;
		end
		compareBit("inReady", expReady, inReady);
		compareBit("outValid", held.size() != 0, outValid);
		if (held.size() != 0)
		begin
			compareData("outRd", xlen'(held[0].rd), xlen'(outRd));
			compareBit("outWe", held[0].we, outWe);
			compareAluOp("outAluOp", held[0].aluOp, outAluOp);
			compareData("opA", held[0].opA, opA);
			compareData("opB", held[0].opB, opB);
		end
		lastAccept = inValid && expReady;
		dispatchNow = held.size() != 0 && outReady && !flush;
		if (lastAccept)
		begin
			next.rd = inRd;
			next.we = inWe;
			next.aluOp = inAluOp;
			next.opA = readModel(inRs1);
			case (inBSel)
				selImm:
				begin
					next.opB = inImm;
				end
				selShamt:
				begin
					next.opB = {27'd0, inImm[4:0]};
				end
				default:
				begin
					next.opB = readModel(inRs2);
				end
			endcase
		end
		if (wbValid && wbAddr != '0)
		begin
			modelRegs[wbAddr] = wbData;
			modelBusy[wbAddr] = 1'b0;
		end
		if (dispatchNow)
		begin
			dispatchCount++;
			if (held[0].we && held[0].rd != '0)
			begin
				modelBusy[held[0].rd] = 1'b1;
				result.due = cycle + 1 + {$random(seed)} % 6;
				result.addr = held[0].rd;
				result.data = held[0].opA + held[0].opB;
				wbQueue.push_back(result);
			end
			void'(held.pop_front());
		end
		else if (held.size() != 0 && flush)
		begin
			// Killed instruction leaves no trace in the model
			flushCount++;
			void'(held.pop_front());
		end
		if (lastAccept)
		begin
			held.push_back(next);
		end
		// Handshake as seen at the DUT boundary
		if (inValid && inReady)
		begin
			acceptCount++;
		end
	endtask

	// Execute back-pressure, flush pulses and commit write-backs
	task automatic driveExecute();
		int pick;
		pick = -1;
		if (fullRate)
		begin
			outReady <= 1'b1;
			flush <= 1'b0;
		end
		else
		begin
			outReady <= {$random(seed)} % 10 < 7;
			flush <= !flush && {$random(seed)} % 100 < 5;
		end
		for (int i = 0; i < wbQueue.size(); i++)
		begin
			if (pick < 0 && wbQueue[i].due <= cycle)
			begin
				pick = i;
			end
		end
		wbValid <= pick >= 0;
		if (pick >= 0)
		begin
			wbAddr <= wbQueue[pick].addr;
			wbData <= wbQueue[pick].data;
			wbQueue.delete(pick);
		end
	endtask

	task automatic stepCycle();
		@(negedge clk);
		checkCycle();
		@(posedge clk);
		cycle++;
		driveExecute();
	endtask

	// Small register range so hazards come often
	task automatic driveDecode();
		inValid <= 1'b1;
		inRs1 <= regAddrWidth'({$random(seed)} % 8);
		inRs2 <= regAddrWidth'({$random(seed)} % 8);
		inRd <= regAddrWidth'({$random(seed)} % 8);
		inWe <= {$random(seed)} % 4 != 0;
		inAluOp <= aluOpT'(4'({$random(seed)} % 10));
		inBSel <= operandSelT'(2'({$random(seed)} % 3));
		inImm <= $random(seed);
	endtask

	task automatic runTraffic(input int count);
		int waited;
		for (int n = 0; n < count; n++)
		begin
			if (!fullRate && {$random(seed)} % 4 == 0)
			begin
				inValid <= 1'b0;
				stepCycle();
			end
			driveDecode();
			waited = 0;
			lastAccept = 1'b0;
			while (!lastAccept && waited < acceptTimeout)
			begin
				stepCycle();
				waited++;
			end
			if (!lastAccept)
			begin
				errorCount++;
				$display("Timeout: instruction %0d was not accepted within %0d cycles",
					n, acceptTimeout);
			end
		end
		inValid <= 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		inValid <= 1'b0;
		while ((held.size() != 0 || wbQueue.size() != 0 || wbValid) && waited < drainTimeout)
		begin
			stepCycle();
			waited++;
		end
		if (waited >= drainTimeout)
		begin
			errorCount++;
			$display("Timeout: pipeline did not drain within %0d cycles", drainTimeout);
		end
		if (acceptCount != dispatchCount + flushCount)
		begin
			errorCount++;
			$display("DUT accepted %0d instructions but %0d were dispatched or flushed",
				acceptCount, dispatchCount + flushCount);
		end
	endtask

	task automatic reportTest(input string name);
		$display("Test %s: %0d checks, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	initial
	begin
		seed = 69;
		cycle = 0;
		checkCount = 0;
		errorCount = 0;
		acceptCount = 0;
		dispatchCount = 0;
		flushCount = 0;
		testErrors = 0;
		testChecks = 0;
		lastAccept = 1'b0;
		fullRate = 1'b0;
		nrst = 1'b0;
		inValid = 1'b0;
		inRs1 = '0;
		inRs2 = '0;
		inRd = '0;
		inWe = 1'b0;
		inAluOp = aluAdd;
		inBSel = selReg;
		inImm = '0;
		wbValid = 1'b0;
		wbAddr = '0;
		wbData = '0;
		flush = 1'b0;
		outReady = 1'b0;
		modelBusy = '0;
		for (int i = 0; i < regCount; i++)
		begin
			modelRegs[i] = '0;
		end

		// Reset held for 8 cycles and then one idle cycle
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			compareBit("outValid", 1'b0, outValid);
			compareBit("inReady", 1'b1, inReady);
		end
		@(posedge clk);
		nrst <= 1'b1;
		stepCycle();
		reportTest("reset");

		runTraffic(2000);
		reportTest("random traffic");

		fullRate = 1'b1;
		runTraffic(500);
		reportTest("full rate");

		fullRate = 1'b0;
		drain();
		if (uut.stage.stageChecks.failCount != 0)
		begin
			errorCount += uut.stage.stageChecks.failCount;
			$display("Bound assertions reported %0d failures",
				uut.stage.stageChecks.failCount);
		end
		reportTest("drain");

		$display("Summary: %0d checks, %0d errors, %0d accepted, %0d dispatched, %0d flushed",
			checkCount, errorCount, acceptCount, dispatchCount, flushCount);
		if (errorCount == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/issue_checker.sv
`timescale 1ns/1ns
`default_nettype none

module issue_checker (
	input logic clk,
	input logic nrst,
	input logic inValid,
	input logic inReady,
	input logic flush,
	input logic outValid,
	input logic outReady,
	input logic [issuePkg::regAddrWidth-1:0] outRd,
	input logic outWe,
	input issuePkg::aluOpT outAluOp,
	input logic [issuePkg::xlen-1:0] opA,
	input logic [issuePkg::xlen-1:0] opB
);

	// Read by the testbench at the end of the run
	int failCount = 0;

	// Issue register comes out of reset empty
	afterReset: assert property (@(posedge clk) $rose(nrst) |-> !outValid)
	else
	begin
		failCount++;
		$error("outValid high in the first cycle after reset");
	end

	heldStable: assert property (@(posedge clk) disable iff (!nrst)
		outValid && !outReady && !flush |=> outValid && $stable(outRd) && $stable(outWe)
		&& $stable(outAluOp) && $stable(opA) && $stable(opB))
	else
	begin
		failCount++;
		$error("out fields changed under back-pressure");
	end

	noAcceptOnFlush: assert property (@(posedge clk) disable iff (!nrst)
		flush |-> !(inValid && inReady))
	else
	begin
		failCount++;
		$error("instruction accepted in a flush cycle");
	end

	// Flushed slot stays empty when nothing new came in
	flushEmpties: assert property (@(posedge clk) disable iff (!nrst)
		flush && !(inValid && inReady) |=> !outValid)
	else
	begin
		failCount++;
		$error("outValid still high after a flush");
	end

endmodule

bind issueStage issue_checker stageChecks (
	.clk(clk),
	.nrst(nrst),
	.inValid(inValid),
	.inReady(inReady),
	.flush(flush),
	.outValid(outValid),
	.outReady(outReady),
	.outRd(outRd),
	.outWe(outWe),
	.outAluOp(outAluOp),
	.opA(opA),
	.opB(opB)
);

`default_nettype wire

//--- source/issuePkg.sv
`default_nettype none

package issuePkg;

	// Datapath and register file sizes
	localparam int xlen = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;

	// Shift amount field taken from the immediate
	localparam int shamtWidth = 5;

	// ALU operations, carried through to execute
	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluAnd  = 4'd2,
		aluOr   = 4'd3,
		aluXor  = 4'd4,
		aluSll  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluSlt  = 4'd8,
		aluSltu = 4'd9
	} aluOpT;

	// Source of operand B
	typedef enum logic [1:0] {
		// Register source 2
		selReg   = 2'd0,
		// Full 32-bit immediate
		selImm   = 2'd1,
		// Low immediate bits, zero-extended
		selShamt = 2'd2
	} operandSelT;

endpackage

`default_nettype wire

//--- source/issueStage.sv
`timescale 1ns/1ns
`default_nettype none

module issueStage (
	input logic clk,
	input logic nrst,

	// Decode side
	input logic inValid,
	output logic inReady,
	input logic [issuePkg::regAddrWidth-1:0] inRd,
	input logic inWe,
	input issuePkg::aluOpT inAluOp,
	input issuePkg::operandSelT inBSel,
	input logic [issuePkg::xlen-1:0] inImm,

	// Register file and scoreboard
	input logic [issuePkg::xlen-1:0] rdataA,
	input logic [issuePkg::xlen-1:0] rdataB,
	input logic hazard,

	// Execute side
	input logic flush,
	input logic outReady,
	output logic outValid,
	output logic [issuePkg::regAddrWidth-1:0] outRd,
	output logic outWe,
	output issuePkg::aluOpT outAluOp,
	output logic [issuePkg::xlen-1:0] opA,
	output logic [issuePkg::xlen-1:0] opB,
	output logic dispatch
);

	import issuePkg::*;

	logic accept;
	logic regFree;
	logic stall;
	logic [xlen-1:0] operandB;

	// Scoreboard does not see inValid
	assign stall = inValid && hazard;

	// Register empty or handing its instruction over this cycle
	assign regFree = !outValid || outReady;

	// A flush cycle never takes a new instruction
	assign inReady = !stall && !flush && regFree;

	assign accept = inValid && inReady;

	// A flushed instruction never reaches execute
	assign dispatch = outValid && outReady && !flush;

	// Operand B select
	always_comb
	begin
		case (inBSel)
			selReg:
			begin
				operandB = rdataB;
			end
			selImm:
			begin
				operandB = inImm;
			end
			selShamt:
			begin
				operandB = {{(xlen-shamtWidth){1'b0}}, inImm[shamtWidth-1:0]};
			end
			default:
			begin
				operandB = rdataB;
			end
		endcase
	end

	// Valid bit of the issue register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			outValid <= 1'b0;
		end
		else if (flush)
		begin
			// Kill the held instruction
			outValid <= 1'b0;
		end
		else if (accept)
		begin
			outValid <= 1'b1;
		end
		else if (dispatch)
		begin
			outValid <= 1'b0;
		end
	end

	// Payload, held while execute applies back-pressure
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			outRd <= inRd;
			outWe <= inWe;
			outAluOp <= inAluOp;
			opA <= rdataA;
			opB <= operandB;
		end
	end

endmodule

`default_nettype wire

//--- source/issueUnit.sv
`timescale 1ns/1ns
`default_nettype none

module issueUnit (
	input logic clk,
	input logic nrst,

	// Decode side
	input logic inValid,
	output logic inReady,
	input logic [issuePkg::regAddrWidth-1:0] inRs1,
	input logic [issuePkg::regAddrWidth-1:0] inRs2,
	input logic [issuePkg::regAddrWidth-1:0] inRd,
	input logic inWe,
	input issuePkg::aluOpT inAluOp,
	input issuePkg::operandSelT inBSel,
	input logic [issuePkg::xlen-1:0] inImm,

	// Commit write-back
	input logic wbValid,
	input logic [issuePkg::regAddrWidth-1:0] wbAddr,
	input logic [issuePkg::xlen-1:0] wbData,

	// Execute side
	input logic flush,
	output logic outValid,
	input logic outReady,
	output logic [issuePkg::regAddrWidth-1:0] outRd,
	output logic outWe,
	output issuePkg::aluOpT outAluOp,
	output logic [issuePkg::xlen-1:0] opA,
	output logic [issuePkg::xlen-1:0] opB
);

	import issuePkg::*;

	logic [xlen-1:0] rdataA;
	logic [xlen-1:0] rdataB;
	logic hazard;
	logic dispatch;

	registerFile regFile (
		.clk(clk),
		.nrst(nrst),
		.raddrA(inRs1),
		.raddrB(inRs2),
		.wen(wbValid),
		.waddr(wbAddr),
		.wdata(wbData),
		.rdataA(rdataA),
		.rdataB(rdataB)
	);

	// Held instruction doubles as the pending write
	scoreboard board (
		.clk(clk),
		.nrst(nrst),
		.rs1(inRs1),
		.rs2(inRs2),
		.rd(inRd),
		.we(inWe),
		.pendingValid(outValid),
		.pendingRd(outRd),
		.pendingWe(outWe),
		.dispatch(dispatch),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.hazard(hazard)
	);

	issueStage stage (
		.clk(clk),
		.nrst(nrst),
		.inValid(inValid),
		.inReady(inReady),
		.inRd(inRd),
		.inWe(inWe),
		.inAluOp(inAluOp),
		.inBSel(inBSel),
		.inImm(inImm),
		.rdataA(rdataA),
		.rdataB(rdataB),
		.hazard(hazard),
		.flush(flush),
		.outReady(outReady),
		.outValid(outValid),
		.outRd(outRd),
		.outWe(outWe),
		.outAluOp(outAluOp),
		.opA(opA),
		.opB(opB),
		.dispatch(dispatch)
	);

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input logic clk,
	input logic nrst,
	input logic [issuePkg::regAddrWidth-1:0] raddrA,
	input logic [issuePkg::regAddrWidth-1:0] raddrB,
	input logic wen,
	input logic [issuePkg::regAddrWidth-1:0] waddr,
	input logic [issuePkg::xlen-1:0] wdata,
	output logic [issuePkg::xlen-1:0] rdataA,
	output logic [issuePkg::xlen-1:0] rdataB
);

	import issuePkg::*;

	logic [xlen-1:0] regs [regCount];

	// One read port, x0 and write-through handled here
	function automatic logic [xlen-1:0] readPort(input logic [regAddrWidth-1:0] addr);
		logic [xlen-1:0] value;
		if (addr == '0)
		begin
			value = '0;
		end
		else if (wen && addr == waddr)
		begin
			// Commit writing this register in the same cycle
			value = wdata;
		end
		else
		begin
			value = regs[addr];
		end
		return value;
	endfunction

	// Write port, x0 is never written
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wen && waddr != '0)
		begin
			regs[waddr] <= wdata;
		end
	end

	always_comb
	begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

endmodule

`default_nettype wire

//--- source/scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module scoreboard (
	input logic clk,
	input logic nrst,
	input logic [issuePkg::regAddrWidth-1:0] rs1,
	input logic [issuePkg::regAddrWidth-1:0] rs2,
	input logic [issuePkg::regAddrWidth-1:0] rd,
	input logic we,
	input logic pendingValid,
	input logic [issuePkg::regAddrWidth-1:0] pendingRd,
	input logic pendingWe,
	input logic dispatch,
	input logic wbValid,
	input logic [issuePkg::regAddrWidth-1:0] wbAddr,
	output logic hazard
);

	import issuePkg::*;

	// One bit per register with a write still in flight past issue
	logic [regCount-1:0] busy;

	logic rs1Hazard;
	logic rs2Hazard;
	logic rdHazard;

	// True when a register may not be used by the offered instruction
	function automatic logic conflict(input logic [regAddrWidth-1:0] addr);
		logic outstanding;
		logic held;
		// A write-back in this cycle frees the register right away
		outstanding = busy[addr] && !(wbValid && wbAddr == addr);
		// The held instruction has no busy bit yet
		held = pendingValid && pendingWe && pendingRd == addr;
		return (addr != '0) && (outstanding || held);
	endfunction

	// Busy bit update, set wins over a clear in the same cycle
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			busy <= '0;
		end
		else
		begin
			if (wbValid)
			begin
				busy[wbAddr] <= 1'b0;
			end
			if (dispatch && pendingWe && pendingRd != '0)
			begin
				busy[pendingRd] <= 1'b1;
			end
		end
	end

	// RAW on both sources, WAW on the destination
	always_comb
	begin
		rs1Hazard = conflict(rs1);
		rs2Hazard = conflict(rs2);
		rdHazard = we && conflict(rd);
	end

	assign hazard = rs1Hazard || rs2Hazard || rdHazard;

endmodule

`default_nettype wire

//--- vlog.f
source/issuePkg.sv
source/registerFile.sv
source/scoreboard.sv
source/issueStage.sv
source/issueUnit.sv
bench/issue_checker.sv
bench/issueBench.sv
